//--- filelist.f
hdl/uart_cmd_pkg.sv
hdl/uart_tx_frame.sv
hdl/uart_rx_frame.sv
hdl/uart_cmd_ctrl.sv
hdl/uart_cmd_bridge.sv
sim/uart_cmd_bridge_checker.sv
sim/uart_cmd_bridge_tb.sv

//--- sim/uart_cmd_bridge_tb.sv
`timescale 1ns/1ps

module uart_cmd_bridge_tb;

  localparam int BR = 8;
  localparam int N_CMDS = 14;
  localparam int RESP_LIMIT = 40 * uart_cmd_pkg::FRAME_BITS * BR;

  logic clk, rst_n, cmd_vld, rx, cmd_rdy, tx, read_rdy, read_err;
  logic [7:0] read_data;
  uart_cmd_pkg::cmd_t cmd_in;
  logic [7:0] dev_regs [128];
  logic [7:0] exp_regs [128];
  logic [31:0] lcg_state = 32'h6135;
  logic bad_parity = 1'b0;
  int errors = 0, tests = 0, passed = 0, frames = 0;

  uart_cmd_bridge #(.BR(BR)) dut_i (.*);

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial
  begin
    #(N_CMDS * RESP_LIMIT * 8 + 10000);
    $display("timeout, the run did not finish in time");
    $display("SOME TESTS FAILED");
    $finish;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
    assert (exp == act) else
    begin
      $display("error: %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  // Device model samples tx at bit centres on falling clock edges
  task automatic recv_tx_frame(output logic [7:0] val);
    logic [10:0] bits;
    @(negedge tx);
    repeat (BR / 2) @(negedge clk);
    bits[0] = tx;
    for (int i = 1; i < uart_cmd_pkg::FRAME_BITS; i++)
    begin
      repeat (BR) @(negedge clk);
      bits[i] = tx;
    end
    val = bits[8:1];
    frames++;
    if (bits[9] != ^bits[8:1] || !bits[10] || bits[0])
    begin
      $display("tx frame has a bad parity, start or stop bit");
      errors++;
    end
  endtask

  task automatic send_rx_frame(logic [7:0] val, logic flip);
    logic [10:0] bits;
    bits = {1'b1, (^val) ^ flip, val, 1'b0};
    @(posedge clk);
    #1;
    for (int i = 0; i < uart_cmd_pkg::FRAME_BITS; i++)
    begin
      rx = bits[i];
      repeat (BR) @(posedge clk);
      #1;
    end
  endtask

  initial
  begin
    logic [7:0] hdr, dat;
    forever
    begin
      recv_tx_frame(hdr);
      if (hdr[7])
      begin
        recv_tx_frame(dat);
        dev_regs[hdr[6:0]] = dat;
      end
      else
      begin
        repeat (2 * BR) @(posedge clk);
        send_rx_frame(dev_regs[hdr[6:0]], bad_parity);
      end
    end
  end

  task automatic issue(uart_cmd_pkg::cmd_t c);
    @(posedge clk);
    #1;
    while (!cmd_rdy)
    begin
      @(posedge clk);
      #1;
    end
    cmd_in = c;
    cmd_vld = 1'b1;
    @(posedge clk);
    #1;
    cmd_vld = 1'b0;
  endtask

  // Waits for the end of the current transaction
  task automatic wait_ready();
    int n;
    n = 0;
    while (!cmd_rdy && n < RESP_LIMIT)
    begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!cmd_rdy)
    begin
      $display("cmd_rdy did not come back after the transaction");
      errors++;
    end
  endtask

  task automatic do_write(logic [6:0] addr, logic [7:0] data);
    issue({1'b1, addr, data});
    exp_regs[addr] = data;
  endtask

  task automatic do_read(logic [6:0] addr, logic exp_err);
    int n;
    issue({1'b0, addr, 8'h00});
    n = 0;
    while (!read_rdy && !read_err && n < RESP_LIMIT)
    begin
      @(posedge clk);
      #1;
      n++;
    end
    if (n >= RESP_LIMIT)
    begin
      $display("no read response arrived for address %h", addr);
      errors++;
    end
    else
    begin
      check_value("read_err", exp_err, read_err);
      check_value("read_rdy", !exp_err, read_rdy);
      check_value("cmd_rdy", 1, cmd_rdy);
      if (!exp_err)
        check_value("read_data", exp_regs[addr], read_data);
    end
  endtask

  task automatic end_test(string name, int err_before);
    tests++;
    if (errors == err_before)
    begin
      passed++;
      $display("test %s: pass", name);
    end
    else
      $display("test %s: fail", name);
  endtask

  initial
  begin
    int e, f;
    logic [6:0] a;
    logic [7:0] d;
    rst_n = 1'b0;
    cmd_vld = 1'b0;
    rx = 1'b1;
    cmd_in = '0;
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;
    e = errors;
    @(posedge clk);
    #1;
    check_value("tx", 1, tx);
    check_value("cmd_rdy", 1, cmd_rdy);
    check_value("read_rdy", 0, read_rdy);
    check_value("read_err", 0, read_err);
    end_test("reset", e);
    e = errors;
    f = frames;
    do_write(7'h2a, 8'hc3);
    wait_ready();
    check_value("dev_regs", 8'hc3, dev_regs[7'h2a]);
    check_value("frames", f + 2, frames);
    end_test("write frames", e);
    e = errors;
    for (int i = 0; i < 4; i++)
    begin
      a = 7'(lcg_next() >> 9);
      d = 8'(lcg_next() >> 13);
      do_write(a, d);
      do_read(a, 1'b0);
    end
    end_test("read back", e);
    e = errors;
    bad_parity = 1'b1;
    do_read(7'h2a, 1'b1);
    bad_parity = 1'b0;
    end_test("parity error", e);
    e = errors;
    f = frames;
    issue({1'b1, 7'h11, 8'h5e});
    exp_regs[7'h11] = 8'h5e;
    cmd_vld = 1'b1;
    cmd_in = {1'b0, 7'h11, 8'h00};
    repeat (20) @(posedge clk);
    #1 cmd_vld = 1'b0;
    do_write(7'h12, 8'ha7);
    do_read(7'h11, 1'b0);
    do_read(7'h12, 1'b0);
    check_value("frames", f + 6, frames);
    end_test("command acceptance", e);
    errors += dut_i.chk_i.fail_cnt;
    $display("%0d tests, %0d passed, %0d errors", tests, passed, errors);
    if (errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

//--- sim/uart_cmd_bridge_checker.sv
`timescale 1ns/1ps

module uart_cmd_bridge_checker (
  input logic                      clk,
  input logic                      rst_n,
  input logic                      cmd_vld,
  input logic                      cmd_rdy,
  input logic                      tx,
  input logic                      tx_busy,
  input logic                      read_rdy,
  input logic                      read_err,
  input uart_cmd_pkg::ctrl_state_e state
);

  int fail_cnt = 0;

  // Line idles high whenever the bridge waits for a command
  idle_high_a: assert property (@(posedge clk) disable iff (!rst_n) cmd_rdy |-> tx)
  else
  begin
    $error("tx low while cmd_rdy high");
    fail_cnt++;
  end

  // Gap between write frames stays high
  gap_high_a: assert property (@(posedge clk) disable iff (!rst_n)
    (state == uart_cmd_pkg::ST_GAP && !tx_busy) |-> tx)
  else
  begin
    $error("tx low during write gap");
    fail_cnt++;
  end

  excl_a: assert property (@(posedge clk) disable iff (!rst_n) !(read_rdy && read_err))
  else
  begin
    $error("read_rdy and read_err high together");
    fail_cnt++;
  end

  rdy_pulse_a: assert property (@(posedge clk) disable iff (!rst_n) read_rdy |=> !read_rdy)
  else
  begin
    $error("read_rdy longer than one cycle");
    fail_cnt++;
  end

  err_pulse_a: assert property (@(posedge clk) disable iff (!rst_n) read_err |=> !read_err)
  else
  begin
    $error("read_err longer than one cycle");
    fail_cnt++;
  end

  accept_a: assert property (@(posedge clk) disable iff (!rst_n)
    (cmd_vld && cmd_rdy) |=> !cmd_rdy)
  else
  begin
    $error("cmd_rdy did not fall after acceptance");
    fail_cnt++;
  end

endmodule

bind uart_cmd_bridge uart_cmd_bridge_checker chk_i (
  .clk      (clk),
  .rst_n    (rst_n),
  .cmd_vld  (cmd_vld),
  .cmd_rdy  (cmd_rdy),
  .tx       (tx),
  .tx_busy  (tx_busy),
  .read_rdy (read_rdy),
  .read_err (read_err),
  .state    (ctrl_i.state)
);

//--- hdl/uart_cmd_bridge.sv
`timescale 1ns/1ps

module uart_cmd_bridge #(
  parameter int BR = 434
) (
  input  logic               clk,
  input  logic               rst_n,
  input  uart_cmd_pkg::cmd_t cmd_in,
  input  logic               cmd_vld,
  output logic               cmd_rdy,
  input  logic               rx,
  output logic               tx,
  output logic [7:0]         read_data,
  output logic               read_rdy,
  output logic               read_err
);

  logic                    tx_start;
  logic                    tx_busy;
  logic                    tx_done;
  uart_cmd_pkg::tx_req_t   tx_req;
  logic                    rx_valid;
  uart_cmd_pkg::rx_frame_t rx_frame;

  uart_cmd_ctrl #(.BR(BR)) ctrl_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx_start  (tx_start),
    .tx_req    (tx_req),
    .tx_busy   (tx_busy),
    .tx_done   (tx_done),
    .rx_valid  (rx_valid),
    .rx_frame  (rx_frame),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  uart_tx_frame #(.BR(BR)) tx_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_req   (tx_req),
    .tx       (tx),
    .tx_busy  (tx_busy),
    .tx_done  (tx_done)
  );

  // Receiver listens all the time and the controller filters by state
  uart_rx_frame #(.BR(BR)) rx_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_valid (rx_valid),
    .rx_frame (rx_frame)
  );

endmodule

//--- hdl/uart_cmd_ctrl.sv
`timescale 1ns/1ps

module uart_cmd_ctrl #(
  parameter int BR = 434
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  uart_cmd_pkg::cmd_t      cmd_in,
  input  logic                    cmd_vld,
  output logic                    cmd_rdy,
  output logic                    tx_start,
  output uart_cmd_pkg::tx_req_t   tx_req,
  input  logic                    tx_busy,
  input  logic                    tx_done,
  input  logic                    rx_valid,
  input  uart_cmd_pkg::rx_frame_t rx_frame,
  output logic [7:0]              read_data,
  output logic                    read_rdy,
  output logic                    read_err
);

  localparam int BAUD_W = $clog2(BR + 1);
  localparam int GAP_W  = $clog2(uart_cmd_pkg::GAP_BITS + 1);

  uart_cmd_pkg::ctrl_state_e state;
  uart_cmd_pkg::cmd_t        cmd_q;

  logic [BAUD_W-1:0] gap_baud;
  logic [GAP_W-1:0]  gap_bits;
  logic              accept;
  logic              gap_tick;
  logic              baud_last;
  logic              bits_last;
  logic              gap_end;
  logic              resp_take;

  assign cmd_rdy = state == uart_cmd_pkg::ST_IDLE;
  assign accept  = cmd_vld && cmd_rdy;

  // Gap only runs once the transmitter has let go of the line
  assign gap_tick  = (state == uart_cmd_pkg::ST_GAP) && !tx_busy;
  assign baud_last = gap_baud == BAUD_W'(BR - 1);
  assign bits_last = gap_bits == GAP_W'(uart_cmd_pkg::GAP_BITS - 1);
  assign gap_end   = gap_tick && baud_last && bits_last;

  assign resp_take = (state == uart_cmd_pkg::ST_WAIT_RESP) && rx_valid;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= uart_cmd_pkg::ST_IDLE;
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      read_err <= 1'b0;
      gap_baud <= '0;
      gap_bits <= '0;
    end
    else
    begin
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      read_err <= 1'b0;
      case (state)
        uart_cmd_pkg::ST_IDLE:
        begin
          if (accept)
          begin
            state    <= uart_cmd_pkg::ST_SEND_HDR;
            tx_start <= 1'b1;
          end
        end
        uart_cmd_pkg::ST_SEND_HDR:
        begin
          if (tx_done)
          begin
            gap_baud <= '0;
            gap_bits <= '0;
            state    <= cmd_q.wr ? uart_cmd_pkg::ST_GAP : uart_cmd_pkg::ST_WAIT_RESP;
          end
        end
        uart_cmd_pkg::ST_GAP:
        begin
          if (gap_end)
          begin
            state    <= uart_cmd_pkg::ST_SEND_DATA;
            tx_start <= 1'b1;
          end
          else if (gap_tick)
          begin
            gap_baud <= baud_last ? '0 : gap_baud + 1'b1;
            gap_bits <= baud_last ? gap_bits + 1'b1 : gap_bits;
          end
        end
        uart_cmd_pkg::ST_SEND_DATA:
        begin
          if (tx_done)
          begin
            state <= uart_cmd_pkg::ST_IDLE;
          end
        end
        uart_cmd_pkg::ST_WAIT_RESP:
        begin
          // Host sees the result as cmd_rdy comes back
          if (resp_take)
          begin
            read_rdy <= rx_frame.par_ok;
            read_err <= !rx_frame.par_ok;
            state    <= uart_cmd_pkg::ST_IDLE;
          end
        end
        default:
        begin
          state <= uart_cmd_pkg::ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd_q           <= cmd_in;
      tx_req.byte_val <= {cmd_in.wr, cmd_in.addr};
    end
    else if (gap_end)
    begin
      tx_req.byte_val <= cmd_q.data;
    end
    if (resp_take)
    begin
      read_data <= rx_frame.byte_val;
    end
  end

endmodule

//--- hdl/uart_rx_frame.sv
`timescale 1ns/1ps

module uart_rx_frame #(
  parameter int BR = 434
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    rx,
  output logic                    rx_valid,
  output uart_cmd_pkg::rx_frame_t rx_frame
);

  localparam int BAUD_W = $clog2(BR + 1);
  localparam int BIT_W  = $clog2(uart_cmd_pkg::FRAME_BITS);

  logic [1:0]                        sync_q;
  logic                              rx_s;
  logic                              rx_prev;
  logic                              start_edge;
  logic                              active;
  logic [BAUD_W-1:0]                 baud_cnt;
  logic [BIT_W-1:0]                  bit_cnt;
  logic [BAUD_W-1:0]                 baud_lim;
  logic                              sample;
  logic                              stop_bit;
  // Data bits and parity, LSB first
  logic [uart_cmd_pkg::DATA_BITS:0]  shift_q;

  assign rx_s       = sync_q[1];
  assign start_edge = rx_prev && !rx_s;

  // Half a period to the start bit centre and full periods after it
  assign baud_lim = (bit_cnt == '0) ? BAUD_W'(BR / 2 - 1) : BAUD_W'(BR - 1);
  assign sample   = active && (baud_cnt == baud_lim);
  assign stop_bit = bit_cnt == BIT_W'(uart_cmd_pkg::FRAME_BITS - 1);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sync_q  <= 2'b11;
      rx_prev <= 1'b1;
    end
    else
    begin
      sync_q  <= {sync_q[0], rx};
      rx_prev <= rx_s;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      active   <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end
    else
    begin
      rx_valid <= 1'b0;
      if (!active)
      begin
        if (start_edge)
        begin
          active   <= 1'b1;
          baud_cnt <= '0;
          bit_cnt  <= '0;
        end
      end
      else if (sample)
      begin
        baud_cnt <= '0;
        if (bit_cnt == '0 && rx_s)
        begin
          // Line back high at mid start bit is a glitch
          active <= 1'b0;
        end
        else if (stop_bit)
        begin
          active   <= 1'b0;
          bit_cnt  <= '0;
          rx_valid <= 1'b1;
        end
        else
        begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
      else
      begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (sample && bit_cnt != '0 && !stop_bit)
    begin
      shift_q <= {rx_s, shift_q[uart_cmd_pkg::DATA_BITS:1]};
    end
    if (sample && stop_bit)
    begin
      rx_frame.byte_val <= shift_q[uart_cmd_pkg::DATA_BITS-1:0];
      rx_frame.par_ok   <= (^shift_q[uart_cmd_pkg::DATA_BITS-1:0]) ==
                           shift_q[uart_cmd_pkg::DATA_BITS];
    end
  end

endmodule

//--- hdl/uart_tx_frame.sv
`timescale 1ns/1ps

module uart_tx_frame #(
  parameter int BR = 434
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  tx_start,
  input  uart_cmd_pkg::tx_req_t tx_req,
  output logic                  tx,
  output logic                  tx_busy,
  output logic                  tx_done
);

  localparam int BAUD_W = $clog2(BR + 1);
  localparam int BIT_W  = $clog2(uart_cmd_pkg::FRAME_BITS);

  logic [uart_cmd_pkg::FRAME_BITS-1:0] shift_q;
  logic [BAUD_W-1:0]                   baud_cnt;
  logic [BIT_W-1:0]                    bit_cnt;
  logic                                bit_end;
  logic                                last_bit;
  logic                                par_bit;

  assign bit_end  = baud_cnt == BAUD_W'(BR - 1);
  assign last_bit = bit_cnt == BIT_W'(uart_cmd_pkg::FRAME_BITS - 1);

  // Even parity over the data byte
  assign par_bit = ^tx_req.byte_val;

  // Registered line output trails the shift register by one cycle
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx <= 1'b1;
    end
    else
    begin
      tx <= shift_q[0];
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      shift_q  <= '1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      tx_busy  <= 1'b0;
      tx_done  <= 1'b0;
    end
    else
    begin
      tx_done <= 1'b0;
      if (tx_start && !tx_busy)
      begin
        shift_q  <= {1'b1, par_bit, tx_req.byte_val, 1'b0};
        baud_cnt <= '0;
        bit_cnt  <= '0;
        tx_busy  <= 1'b1;
      end
      else if (tx_busy)
      begin
        if (bit_end)
        begin
          baud_cnt <= '0;
          // Shift in ones so the line idles high after the stop bit
          shift_q  <= {1'b1, shift_q[uart_cmd_pkg::FRAME_BITS-1:1]};
          if (last_bit)
          begin
            bit_cnt <= '0;
            tx_busy <= 1'b0;
            tx_done <= 1'b1;
          end
          else
          begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        else
        begin
          baud_cnt <= baud_cnt + 1'b1;
        end
      end
    end
  end

endmodule

//--- hdl/uart_cmd_pkg.sv
package uart_cmd_pkg;

  // Field widths of the host command word
  localparam int ADDR_BITS = 7;
  localparam int DATA_BITS = 8;

  // Start, eight data, even parity and stop
  localparam int FRAME_BITS = 11;

  // Idle bit periods between the header and data frames of a write
  localparam int GAP_BITS = 16;

  // Host command, bit 15 down to bit 0
  typedef struct packed {
    logic                 wr;
    logic [ADDR_BITS-1:0] addr;
    logic [DATA_BITS-1:0] data;
  } cmd_t;

  // One byte for the transmitter to frame and send
  typedef struct packed {
    logic [DATA_BITS-1:0] byte_val;
  } tx_req_t;

  // One received frame with its parity status
  typedef struct packed {
    logic [DATA_BITS-1:0] byte_val;
    logic                 par_ok;
  } rx_frame_t;

  // Controller states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SEND_HDR,
    ST_GAP,
    ST_SEND_DATA,
    ST_WAIT_RESP
  } ctrl_state_e;

  // Write flag in the top bit of the header and address below it
  // Header frame is sent before either data or a read response
  // A read header has the write flag clear
  //
  // Frame on the line, first bit first:
  //   start (0)
  //   data[0] .. data[7]
  //   parity (XOR of data)
  //   stop (1)
  //
  // Idle line level is high

endpackage
